/* hw/opc_pkg.sv */
// #########################################################
// Constants, register-address union and instruction structs
// shared by the operand collector stage
// #########################################################
package opc_pkg;

    // #########################################################
    // Constants
    // #########################################################

    // Source operands carried by one instruction
    localparam int unsigned OPERANDS_PER_INST = 2;

    // Warps and per-warp register indexing
    localparam int unsigned NUM_WARPS = 4;
    localparam int unsigned WID_W     = 2;
    localparam int unsigned REG_IDX_W = 4;

    // Bank geometry
    localparam int unsigned NUM_BANKS   = 4;
    localparam int unsigned BANK_SEL_W  = 2;
    localparam int unsigned BANK_ADDR_W = 4;

    // One warp register
    localparam int unsigned DATA_W = 32;

    // Tag bits above the warp id
    localparam int unsigned SLOT_W = 3;

    // #########################################################
    // Types
    // #########################################################

    // Slot in the upper bits, warp id in the low WID_W bits
    typedef logic [SLOT_W+WID_W-1:0] tag_t;
    typedef logic [DATA_W-1:0]       data_t;

    // One register address seen two ways
    // Bank select is the low index bits, row is warp id plus upper index bits
    typedef union packed {
        struct packed {
            logic [WID_W-1:0]     wid;
            logic [REG_IDX_W-1:0] idx;
        } flat;
        struct packed {
            logic [BANK_ADDR_W-1:0] row;
            logic [BANK_SEL_W-1:0]  bank;
        } banked;
    } reg_addr_u;

    // Instruction from the dispatcher
    typedef struct packed {
        tag_t                                        tag;
        logic [REG_IDX_W-1:0]                        dst;
        logic [OPERANDS_PER_INST-1:0][REG_IDX_W-1:0] src;
    } disp_inst_t;

    // Instruction with operands, towards the execution units
    typedef struct packed {
        tag_t                           tag;
        logic [REG_IDX_W-1:0]           dst;
        data_t [OPERANDS_PER_INST-1:0]  operands;
    } opc_inst_t;

    // Write-back of a whole warp register
    typedef struct packed {
        logic [WID_W-1:0]     wid;
        logic [REG_IDX_W-1:0] dst;
        data_t                data;
    } wb_req_t;

    // Operand read request
    typedef struct packed {
        reg_addr_u addr;
    } rd_req_t;

endpackage

/* hw/register_bank.sv */
`timescale 1ns/1ps
// #########################################################
// Single-port register bank
// Write-back has priority, reads are registered and tagged
// #########################################################
module register_bank import opc_pkg::*; #(
    parameter int unsigned BANK_ID = 0,
    parameter int unsigned PORT_W  = 3
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   wb_valid_i,
    input  wb_req_t                wb_req_i,
    output logic                   busy_o,
    input  logic                   rd_valid_i,
    input  logic [BANK_ADDR_W-1:0] rd_addr_i,
    input  logic [PORT_W-1:0]      rd_port_i,
    output logic                   rsp_valid_o,
    output logic [PORT_W-1:0]      rsp_port_o,
    output data_t                  rsp_data_o
);
    // Register file spread evenly over the banks
    localparam int unsigned ROWS = NUM_WARPS * (2 ** REG_IDX_W) / NUM_BANKS;

    data_t     mem [ROWS];
    reg_addr_u wb_addr;

    // Flat write address, decoded through the banked view below
    always_comb begin
        wb_addr.flat.wid = wb_req_i.wid;
        wb_addr.flat.idx = wb_req_i.dst;
    end

    // Write targets this bank
    assign busy_o = wb_valid_i && (wb_addr.banked.bank == BANK_SEL_W'(BANK_ID));

    // Storage, cleared to zero on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 0; r < ROWS; r++) begin
                mem[r] <= '0;
            end
        end else if (busy_o) begin
            mem[wb_addr.banked.row] <= wb_req_i.data;
        end
    end

    // Read response one cycle after the request
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= rd_valid_i;
        end
    end

    // Port index rides along with the data
    always_ff @(posedge clk_i) begin
        if (rd_valid_i) begin
            rsp_port_o <= rd_port_i;
            rsp_data_o <= mem[rd_addr_i];
        end
    end

    // Crossbar must hold back reads while this bank writes
    rd_during_wr_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rd_valid_i |-> !busy_o)
        else $error("bank %0d took a read during a write", BANK_ID);

endmodule

/* hw/bank_read_crossbar.sv */
`timescale 1ns/1ps
// #########################################################
// Per-bank round-robin read arbiters
// Return routing of bank read data to the request ports
// #########################################################
module bank_read_crossbar import opc_pkg::*; #(
    parameter  int unsigned NUM_COLLECTORS = 3,
    localparam int unsigned NUM_PORTS      = NUM_COLLECTORS * OPERANDS_PER_INST,
    localparam int unsigned PORT_W         = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    // Collector side
    input  logic    [NUM_PORTS-1:0]               req_valid_i,
    input  rd_req_t [NUM_PORTS-1:0]               req_i,
    output logic    [NUM_PORTS-1:0]               grant_o,
    // Bank side
    input  logic [NUM_BANKS-1:0]                  bank_busy_i,
    output logic [NUM_BANKS-1:0]                  bank_rd_valid_o,
    output logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] bank_rd_addr_o,
    output logic [NUM_BANKS-1:0][PORT_W-1:0]      bank_rd_port_o,
    input  logic [NUM_BANKS-1:0]                  bank_rsp_valid_i,
    input  logic [NUM_BANKS-1:0][PORT_W-1:0]      bank_rsp_port_i,
    input  data_t [NUM_BANKS-1:0]                 bank_rsp_data_i,
    // Responses back to the collectors
    output logic  [NUM_PORTS-1:0]                 rsp_valid_o,
    output data_t [NUM_PORTS-1:0]                 rsp_data_o
);
    // Grant of each bank as seen by each port
    logic [NUM_PORTS-1:0][NUM_BANKS-1:0] port_grant;
    // Response of each bank as seen by each port
    logic [NUM_PORTS-1:0][NUM_BANKS-1:0] port_rsp;

    // #########################################################
    // Read arbiters, one per bank
    // #########################################################

    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank_arb
        logic [NUM_PORTS-1:0] hit;
        logic [PORT_W-1:0]    rr_ptr_q;
        logic [PORT_W-1:0]    winner;
        logic                 found;

        // Ports requesting this bank
        always_comb begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                hit[p] = req_valid_i[p] && (req_i[p].addr.banked.bank == BANK_SEL_W'(b));
            end
        end

        // First requester at or after the pointer
        always_comb begin
            int unsigned idx;
            found  = 1'b0;
            winner = rr_ptr_q;
            for (int unsigned i = 0; i < NUM_PORTS; i++) begin
                idx = rr_ptr_q + i;
                if (idx >= NUM_PORTS) begin
                    idx = idx - NUM_PORTS;
                end
                if (!found && hit[idx]) begin
                    found  = 1'b1;
                    winner = PORT_W'(idx);
                end
            end
        end

        // A writing bank grants nothing, request stays pending
        assign bank_rd_valid_o[b] = found && !bank_busy_i[b];
        assign bank_rd_addr_o[b]  = req_i[winner].addr.banked.row;
        assign bank_rd_port_o[b]  = winner;

        // Pointer moves past the winner on a grant only
        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                rr_ptr_q <= '0;
            end else if (bank_rd_valid_o[b]) begin
                rr_ptr_q <= (winner == PORT_W'(NUM_PORTS - 1)) ? '0 : winner + 1'b1;
            end
        end
    end

    // #########################################################
    // Grant fan-out and response routing
    // #########################################################

    always_comb begin
        port_grant  = '0;
        port_rsp    = '0;
        rsp_valid_o = '0;
        rsp_data_o  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                port_grant[p][b] = bank_rd_valid_o[b] && (bank_rd_port_o[b] == PORT_W'(p));
                // Returned port index picks the destination
                port_rsp[p][b]   = bank_rsp_valid_i[b] && (bank_rsp_port_i[b] == PORT_W'(p));
                if (port_rsp[p][b]) begin
                    rsp_valid_o[p] = 1'b1;
                    rsp_data_o[p]  = bank_rsp_data_i[b];
                end
            end
            grant_o[p] = |port_grant[p];
        end
    end

    // One bank at most answers a port per cycle
    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port_chk
        one_bank_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            $onehot0(port_rsp[p]))
            else $error("port %0d served by several banks", p);
    end

endmodule

/* hw/operand_collector.sv */
`timescale 1ns/1ps
// #########################################################
// Operand collector slot
// Holds one instruction, reads its operands, offers it out
// #########################################################
module operand_collector import opc_pkg::*; (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    // Insert from the dispatcher
    input  logic                            insert_valid_i,
    input  disp_inst_t                      inst_i,
    output logic                            idle_o,
    // Register reads
    output logic    [OPERANDS_PER_INST-1:0] rd_valid_o,
    output rd_req_t [OPERANDS_PER_INST-1:0] rd_req_o,
    input  logic    [OPERANDS_PER_INST-1:0] rd_grant_i,
    input  logic    [OPERANDS_PER_INST-1:0] rsp_valid_i,
    input  data_t   [OPERANDS_PER_INST-1:0] rsp_data_i,
    // Finished instruction
    output logic                            done_valid_o,
    output opc_inst_t                       done_inst_o,
    input  logic                            done_ready_i
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_DONE
    } state_e;

    state_e                         state_q;
    state_e                         state_d;
    // Operand still to be requested
    logic [OPERANDS_PER_INST-1:0]   req_pend_q;
    // Operand granted, data due next cycle
    logic [OPERANDS_PER_INST-1:0]   wait_rsp_q;
    logic [OPERANDS_PER_INST-1:0]   op_ready;
    disp_inst_t                     inst_q;
    data_t [OPERANDS_PER_INST-1:0]  operand_q;

    // Operand is in, or lands this cycle
    assign op_ready = ~req_pend_q & (~wait_rsp_q | rsp_valid_i);

    // #########################################################
    // Slot FSM
    // #########################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (insert_valid_i) begin
                    state_d = ST_COLLECT;
                end
            end
            ST_COLLECT: begin
                if (&op_ready) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                if (done_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            req_pend_q <= '0;
            wait_rsp_q <= '0;
        end else begin
            state_q <= state_d;
            if (idle_o && insert_valid_i) begin
                req_pend_q <= '1;
                wait_rsp_q <= '0;
            end else begin
                // Request dropped once granted
                req_pend_q <= req_pend_q & ~(rd_valid_o & rd_grant_i);
                wait_rsp_q <= (wait_rsp_q & ~rsp_valid_i) | (rd_valid_o & rd_grant_i);
            end
        end
    end

    // Instruction and operand payload
    always_ff @(posedge clk_i) begin
        if (idle_o && insert_valid_i) begin
            inst_q <= inst_i;
        end
        for (int o = 0; o < OPERANDS_PER_INST; o++) begin
            if (rsp_valid_i[o]) begin
                operand_q[o] <= rsp_data_i[o];
            end
        end
    end

    // Operand address is the tag's warp id plus the source index
    always_comb begin
        for (int o = 0; o < OPERANDS_PER_INST; o++) begin
            rd_valid_o[o]             = (state_q == ST_COLLECT) && req_pend_q[o];
            rd_req_o[o].addr.flat.wid = inst_q.tag[WID_W-1:0];
            rd_req_o[o].addr.flat.idx = inst_q.src[o];
        end
    end

    assign idle_o       = (state_q == ST_IDLE);
    assign done_valid_o = (state_q == ST_DONE);
    assign done_inst_o  = '{tag: inst_q.tag, dst: inst_q.dst, operands: operand_q};

    // Data only comes back for a read granted the cycle before
    for (genvar o = 0; o < OPERANDS_PER_INST; o++) begin : gen_rsp_chk
        rsp_after_grant_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            rsp_valid_i[o] |-> wait_rsp_q[o])
            else $error("operand %0d response without a grant", o);
    end

endmodule

/* hw/collector_output_arbiter.sv */
`timescale 1ns/1ps
// #########################################################
// Round-robin selection of finished collectors
// onto the execution output
// #########################################################
module collector_output_arbiter import opc_pkg::*; #(
    parameter  int unsigned NUM_COLLECTORS = 3,
    localparam int unsigned SEL_W = (NUM_COLLECTORS > 1) ? $clog2(NUM_COLLECTORS) : 1
) (
    input  logic                                 clk_i,
    input  logic                                 arst_n_i,
    input  logic      [NUM_COLLECTORS-1:0]       in_valid_i,
    input  opc_inst_t [NUM_COLLECTORS-1:0]       in_inst_i,
    output logic      [NUM_COLLECTORS-1:0]       in_ready_o,
    output logic                                 out_valid_o,
    output opc_inst_t                            out_inst_o,
    input  logic                                 out_ready_i
);
    logic [SEL_W-1:0] rr_ptr_q;
    logic [SEL_W-1:0] sel_q;
    logic [SEL_W-1:0] sel;
    // Last cycle ended in a stall
    logic             hold_q;
    logic             found;

    // First valid collector at or after the pointer
    always_comb begin
        int unsigned idx;
        found = 1'b0;
        sel   = rr_ptr_q;
        for (int unsigned i = 0; i < NUM_COLLECTORS; i++) begin
            idx = rr_ptr_q + i;
            if (idx >= NUM_COLLECTORS) begin
                idx = idx - NUM_COLLECTORS;
            end
            if (!found && in_valid_i[idx]) begin
                found = 1'b1;
                sel   = SEL_W'(idx);
            end
        end
        // Stalled winner keeps the output
        if (hold_q) begin
            sel = sel_q;
        end
    end

    assign out_valid_o = in_valid_i[sel];
    assign out_inst_o  = in_inst_i[sel];

    always_comb begin
        in_ready_o      = '0;
        in_ready_o[sel] = out_valid_o && out_ready_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q <= '0;
            sel_q    <= '0;
            hold_q   <= 1'b0;
        end else begin
            sel_q  <= sel;
            hold_q <= out_valid_o && !out_ready_i;
            if (out_valid_o && out_ready_i) begin
                rr_ptr_q <= (sel == SEL_W'(NUM_COLLECTORS - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    // Stalled output stays put until taken
    stall_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_inst_o))
        else $error("output changed while stalled");

endmodule

/* hw/register_opc_stage.sv */
`timescale 1ns/1ps
// #########################################################
// Register file and operand collector stage, top level
// Insert selection, collector and bank arrays
// #########################################################
module register_opc_stage import opc_pkg::*; #(
    parameter int unsigned NUM_COLLECTORS = 3
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // Dispatcher
    input  logic       disp_valid_i,
    input  disp_inst_t disp_inst_i,
    output logic       disp_ready_o,
    // Write-back from the execution units
    input  logic       wb_valid_i,
    input  wb_req_t    wb_req_i,
    // Execution output
    output logic       opc_valid_o,
    output opc_inst_t  opc_inst_o,
    input  logic       eu_ready_i
);
    localparam int unsigned NUM_PORTS = NUM_COLLECTORS * OPERANDS_PER_INST;
    localparam int unsigned PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // #########################################################
    // Signals
    // #########################################################

    // Collector side
    logic      [NUM_COLLECTORS-1:0] idle;
    logic      [NUM_COLLECTORS-1:0] insert_valid;
    logic      [NUM_COLLECTORS-1:0] done_valid;
    logic      [NUM_COLLECTORS-1:0] done_ready;
    opc_inst_t [NUM_COLLECTORS-1:0] done_inst;

    // Read ports, OPERANDS_PER_INST per collector
    logic    [NUM_PORTS-1:0] req_valid;
    rd_req_t [NUM_PORTS-1:0] req;
    logic    [NUM_PORTS-1:0] req_grant;
    logic    [NUM_PORTS-1:0] rsp_valid;
    data_t   [NUM_PORTS-1:0] rsp_data;

    // Bank side
    logic  [NUM_BANKS-1:0]                  bank_busy;
    logic  [NUM_BANKS-1:0]                  bank_rd_valid;
    logic  [NUM_BANKS-1:0][BANK_ADDR_W-1:0] bank_rd_addr;
    logic  [NUM_BANKS-1:0][PORT_W-1:0]      bank_rd_port;
    logic  [NUM_BANKS-1:0]                  bank_rsp_valid;
    logic  [NUM_BANKS-1:0][PORT_W-1:0]      bank_rsp_port;
    data_t [NUM_BANKS-1:0]                  bank_rsp_data;

    // #########################################################
    // Insert selection and collectors
    // #########################################################

    // Only the lowest idle collector sees the insert
    always_comb begin
        logic taken;
        taken        = 1'b0;
        insert_valid = '0;
        for (int c = 0; c < NUM_COLLECTORS; c++) begin
            if (idle[c] && !taken) begin
                insert_valid[c] = disp_valid_i;
                taken           = 1'b1;
            end
        end
    end

    assign disp_ready_o = |idle;

    for (genvar c = 0; c < NUM_COLLECTORS; c++) begin : gen_collectors
        operand_collector i_operand_collector (
            .clk_i          (clk_i),
            .arst_n_i       (arst_n_i),
            .insert_valid_i (insert_valid[c]),
            .inst_i         (disp_inst_i),
            .idle_o         (idle[c]),
            .rd_valid_o     (req_valid[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rd_req_o       (req[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rd_grant_i     (req_grant[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rsp_valid_i    (rsp_valid[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .rsp_data_i     (rsp_data[c*OPERANDS_PER_INST +: OPERANDS_PER_INST]),
            .done_valid_o   (done_valid[c]),
            .done_inst_o    (done_inst[c]),
            .done_ready_i   (done_ready[c])
        );
    end

    // #########################################################
    // Read crossbar and banks
    // #########################################################

    bank_read_crossbar #(
        .NUM_COLLECTORS (NUM_COLLECTORS)
    ) i_bank_read_crossbar (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .req_valid_i      (req_valid),
        .req_i            (req),
        .grant_o          (req_grant),
        .bank_busy_i      (bank_busy),
        .bank_rd_valid_o  (bank_rd_valid),
        .bank_rd_addr_o   (bank_rd_addr),
        .bank_rd_port_o   (bank_rd_port),
        .bank_rsp_valid_i (bank_rsp_valid),
        .bank_rsp_port_i  (bank_rsp_port),
        .bank_rsp_data_i  (bank_rsp_data),
        .rsp_valid_o      (rsp_valid),
        .rsp_data_o       (rsp_data)
    );

    // Every bank sees the write-back and claims its own
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_banks
        register_bank #(
            .BANK_ID (b),
            .PORT_W  (PORT_W)
        ) i_register_bank (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .wb_valid_i  (wb_valid_i),
            .wb_req_i    (wb_req_i),
            .busy_o      (bank_busy[b]),
            .rd_valid_i  (bank_rd_valid[b]),
            .rd_addr_i   (bank_rd_addr[b]),
            .rd_port_i   (bank_rd_port[b]),
            .rsp_valid_o (bank_rsp_valid[b]),
            .rsp_port_o  (bank_rsp_port[b]),
            .rsp_data_o  (bank_rsp_data[b])
        );
    end

    // #########################################################
    // Execution output
    // #########################################################

    collector_output_arbiter #(
        .NUM_COLLECTORS (NUM_COLLECTORS)
    ) i_collector_output_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (done_valid),
        .in_inst_i   (done_inst),
        .in_ready_o  (done_ready),
        .out_valid_o (opc_valid_o),
        .out_inst_o  (opc_inst_o),
        .out_ready_i (eu_ready_i)
    );

endmodule

/* dv/tb_checks.svh */
// #########################################################
// Error counters, typed compare tasks and Galois LFSR
// #########################################################
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Check and failure counts
int check_cnt    = 0;
int mismatch_cnt = 0;
int error_cnt    = 0;

// Galois LFSR state, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'hc315;

// One step, one bit out
function automatic logic next_lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out_bit;
endfunction

// Full register word, one step per bit
function automatic data_t random_word();
    data_t word;
    word = '0;
    for (int i = 0; i < DATA_W; i++) begin
        word[i] = next_lfsr_bit();
    end
    return word;
endfunction

task automatic compare_data(input string name, input data_t exp_val, input data_t act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
        mismatch_cnt++;
        $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
    end
endtask

task automatic compare_tag(input string name, input tag_t exp_val, input tag_t act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
        mismatch_cnt++;
        $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
    end
endtask

// Destination register index
task automatic compare_dst(input string name, input logic [REG_IDX_W-1:0] exp_val,
                           input logic [REG_IDX_W-1:0] act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
        mismatch_cnt++;
        $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
    end
endtask

`endif

/* dv/tb_register_opc_stage.sv */
`timescale 1ns/1ps
// #########################################################
// Testbench for the register file and operand collector stage
// Stimulus table, reference register model, timeout
// #########################################################
module tb_register_opc_stage import opc_pkg::*; ();

    // Table row: write-back or dispatch, optional drain before it
    typedef struct packed {
        logic                 is_wb;
        logic                 drain;
        tag_t                 tag;
        logic [WID_W-1:0]     wid;
        logic [REG_IDX_W-1:0] dst;
        logic [REG_IDX_W-1:0] src0;
        logic [REG_IDX_W-1:0] src1;
    } stim_t;

    localparam int NUM_STIM       = 32;
    localparam int TIMEOUT_CYCLES = NUM_STIM * 20;
    localparam int NUM_TAGS       = 2 ** (SLOT_W + WID_W);

    // Columns: is_wb, drain, tag, wid (write-back), dst, src0, src1
    localparam stim_t STIM_TABLE [NUM_STIM] = '{
        // Reads straight after reset, with and without bank conflicts
        '{1'b0, 1'b0, 5'b000_00, 2'd0, 4'd1,  4'd0,  4'd5},
        '{1'b0, 1'b0, 5'b000_01, 2'd0, 4'd2,  4'd3,  4'd7},
        '{1'b0, 1'b0, 5'b000_10, 2'd0, 4'd3,  4'd15, 4'd10},
        '{1'b0, 1'b0, 5'b000_11, 2'd0, 4'd4,  4'd4,  4'd8},
        // Fill registers once everything has drained
        '{1'b1, 1'b1, 5'b000_00, 2'd0, 4'd5,  4'd0,  4'd0},
        '{1'b1, 1'b0, 5'b000_00, 2'd0, 4'd0,  4'd0,  4'd0},
        '{1'b1, 1'b0, 5'b000_00, 2'd1, 4'd3,  4'd0,  4'd0},
        '{1'b1, 1'b0, 5'b000_00, 2'd1, 4'd7,  4'd0,  4'd0},
        '{1'b1, 1'b0, 5'b000_00, 2'd2, 4'd10, 4'd0,  4'd0},
        '{1'b1, 1'b0, 5'b000_00, 2'd3, 4'd4,  4'd0,  4'd0},
        '{1'b1, 1'b0, 5'b000_00, 2'd3, 4'd8,  4'd0,  4'd0},
        // Read back written values
        '{1'b0, 1'b0, 5'b001_00, 2'd0, 4'd3,  4'd5,  4'd0},
        '{1'b0, 1'b0, 5'b001_01, 2'd0, 4'd6,  4'd3,  4'd7},
        '{1'b0, 1'b0, 5'b001_10, 2'd0, 4'd9,  4'd10, 4'd10},
        '{1'b0, 1'b0, 5'b001_11, 2'd0, 4'd11, 4'd4,  4'd8},
        // Bank 0 writes while bank 0 reads are pending
        '{1'b0, 1'b0, 5'b010_00, 2'd0, 4'd12, 4'd0,  4'd4},
        '{1'b1, 1'b0, 5'b000_00, 2'd0, 4'd12, 4'd0,  4'd0},
        '{1'b1, 1'b0, 5'b000_00, 2'd3, 4'd0,  4'd0,  4'd0},
        '{1'b0, 1'b0, 5'b011_00, 2'd0, 4'd13, 4'd12, 4'd0},
        '{1'b0, 1'b0, 5'b010_11, 2'd0, 4'd14, 4'd0,  4'd4},
        // Several warps in flight under back-pressure
        '{1'b1, 1'b0, 5'b000_00, 2'd1, 4'd9,  4'd0,  4'd0},
        '{1'b0, 1'b0, 5'b010_01, 2'd0, 4'd15, 4'd9,  4'd3},
        '{1'b0, 1'b0, 5'b011_10, 2'd0, 4'd1,  4'd15, 4'd2},
        '{1'b0, 1'b0, 5'b100_00, 2'd0, 4'd2,  4'd5,  4'd12},
        '{1'b0, 1'b0, 5'b100_01, 2'd0, 4'd3,  4'd7,  4'd9},
        '{1'b1, 1'b1, 5'b000_00, 2'd2, 4'd15, 4'd0,  4'd0},
        '{1'b0, 1'b0, 5'b100_10, 2'd0, 4'd4,  4'd15, 4'd15},
        '{1'b0, 1'b0, 5'b100_11, 2'd0, 4'd5,  4'd8,  4'd0},
        '{1'b0, 1'b0, 5'b101_00, 2'd0, 4'd6,  4'd1,  4'd2},
        // Overwrite, then the last value must come back
        '{1'b1, 1'b1, 5'b000_00, 2'd0, 4'd5,  4'd0,  4'd0},
        '{1'b0, 1'b0, 5'b110_00, 2'd0, 4'd7,  4'd5,  4'd5},
        '{1'b0, 1'b0, 5'b101_10, 2'd0, 4'd8,  4'd10, 4'd14}
    };

    logic       clk_i;
    logic       arst_n_i;
    logic       disp_valid_i;
    disp_inst_t disp_inst_i;
    logic       disp_ready_o;
    logic       wb_valid_i;
    wb_req_t    wb_req_i;
    logic       opc_valid_o;
    opc_inst_t  opc_inst_o;
    logic       eu_ready_i;

    // Reference register file, indexed by the flat address view
    data_t     ref_regs [2 ** (WID_W + REG_IDX_W)];
    // Pending instructions by tag
    logic      exp_valid [NUM_TAGS];
    opc_inst_t exp_inst [NUM_TAGS];
    int        dispatched_cnt = 0;
    int        retired_cnt    = 0;
    int        cycle_cnt      = 0;
    // Output offered but not taken at the last falling edge
    logic      stalled        = 1'b0;
    tag_t      stalled_tag    = '0;

    `include "tb_checks.svh"

    register_opc_stage #(
        .NUM_COLLECTORS (3)
    ) i_register_opc_stage (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .disp_valid_i (disp_valid_i),
        .disp_inst_i  (disp_inst_i),
        .disp_ready_o (disp_ready_o),
        .wb_valid_i   (wb_valid_i),
        .wb_req_i     (wb_req_i),
        .opc_valid_o  (opc_valid_o),
        .opc_inst_o   (opc_inst_o),
        .eu_ready_i   (eu_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic reg_addr_u flat_addr(input logic [WID_W-1:0] wid,
                                            input logic [REG_IDX_W-1:0] idx);
        reg_addr_u addr;
        addr.flat.wid = wid;
        addr.flat.idx = idx;
        return addr;
    endfunction

    // Instruction leaving the stage, matched by tag
    task automatic check_result(input opc_inst_t got);
        string name;
        name = $sformatf("tag %02h", got.tag);
        if (!exp_valid[got.tag]) begin
            error_cnt++;
            $display("tag %02h came out without a pending dispatch", got.tag);
        end else begin
            exp_valid[got.tag] = 1'b0;
            retired_cnt++;
            compare_dst({name, " dst"}, exp_inst[got.tag].dst, got.dst);
            compare_data({name, " operand 0"}, exp_inst[got.tag].operands[0], got.operands[0]);
            compare_data({name, " operand 1"}, exp_inst[got.tag].operands[1], got.operands[1]);
        end
    endtask

    // Falling edge, random back-pressure, output handshake for the next rising edge
    task automatic next_cycle();
        @(negedge clk_i);
        // A stalled output must still be there, unchanged
        if (stalled) begin
            if (!opc_valid_o) begin
                error_cnt++;
                $display("output valid dropped while stalled");
            end else begin
                compare_tag("stalled output tag", stalled_tag, opc_inst_o.tag);
            end
        end
        eu_ready_i  = next_lfsr_bit();
        stalled     = opc_valid_o && !eu_ready_i;
        stalled_tag = opc_inst_o.tag;
        if (opc_valid_o && eu_ready_i) begin
            check_result(opc_inst_o);
        end
    endtask

    task automatic wait_drain();
        while (dispatched_cnt != retired_cnt) begin
            next_cycle();
        end
    endtask

    task automatic write_back(input logic [WID_W-1:0] wid, input logic [REG_IDX_W-1:0] dst);
        data_t data;
        data           = random_word();
        wb_req_i.wid   = wid;
        wb_req_i.dst   = dst;
        wb_req_i.data  = data;
        wb_valid_i     = 1'b1;
        ref_regs[flat_addr(wid, dst)] = data;
        next_cycle();
        wb_valid_i = 1'b0;
    endtask

    task automatic dispatch(input stim_t s);
        logic [WID_W-1:0] wid;
        wid                = s.tag[WID_W-1:0];
        disp_inst_i.tag    = s.tag;
        disp_inst_i.dst    = s.dst;
        disp_inst_i.src[0] = s.src0;
        disp_inst_i.src[1] = s.src1;
        disp_valid_i       = 1'b1;
        // Hold the request until a collector is free
        while (!disp_ready_o) begin
            next_cycle();
        end
        if (exp_valid[s.tag]) begin
            error_cnt++;
            $display("tag %02h dispatched twice in one pass", s.tag);
        end
        exp_valid[s.tag]            = 1'b1;
        exp_inst[s.tag].tag         = s.tag;
        exp_inst[s.tag].dst         = s.dst;
        exp_inst[s.tag].operands[0] = ref_regs[flat_addr(wid, s.src0)];
        exp_inst[s.tag].operands[1] = ref_regs[flat_addr(wid, s.src1)];
        dispatched_cnt++;
        next_cycle();
        disp_valid_i = 1'b0;
    endtask

    // Run limit
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        arst_n_i     = 1'b0;
        disp_valid_i = 1'b0;
        disp_inst_i  = '0;
        wb_valid_i   = 1'b0;
        wb_req_i     = '0;
        eu_ready_i   = 1'b0;
        for (int i = 0; i < $size(ref_regs); i++) begin
            ref_regs[i] = '0;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
            exp_valid[t] = 1'b0;
            exp_inst[t]  = '0;
        end
        repeat (5) @(negedge clk_i);
        arst_n_i = 1'b1;
        if (!disp_ready_o || opc_valid_o) begin
            error_cnt++;
            $display("stage is not idle after reset");
        end
        for (int e = 0; e < NUM_STIM; e++) begin
            if (STIM_TABLE[e].drain) begin
                wait_drain();
            end
            if (STIM_TABLE[e].is_wb) begin
                write_back(STIM_TABLE[e].wid, STIM_TABLE[e].dst);
            end else begin
                dispatch(STIM_TABLE[e]);
            end
        end
        wait_drain();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, error_cnt);
        if (mismatch_cnt == 0 && error_cnt == 0 && check_cnt > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+dv
hw/opc_pkg.sv
hw/register_bank.sv
hw/bank_read_crossbar.sv
hw/operand_collector.sv
hw/collector_output_arbiter.sv
hw/register_opc_stage.sv
dv/tb_register_opc_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -u

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f verilog.f \
    --top-module tb_register_opc_stage -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG_FILE"; then
    exit 0
fi
exit 1
